// File: Bender.yml
package:
  name: btb

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/btb_addr_pkg.sv
      - common/btb_entry_pkg.sv
      - btb/btb_update_decode.sv
      - btb/btb_entry.sv
      - btb/btb_lookup_select.sv
      - hdl/btb_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/btb_props.sv
      - test/btb_tb.sv

// File: btb/btb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module btb_entry (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       write_en,    // this entry's decoded strobe
    input  btb_addr_pkg::btb_tag_t     wr_tag,
    input  btb_entry_pkg::btb_target_t wr_target,
    input  btb_entry_pkg::btb_fip_t    wr_fip_e,
    input  btb_entry_pkg::btb_fip_t    wr_fip_o,
    input  btb_addr_pkg::btb_tag_t     lookup_tag,  // from the fetch eip
    output logic                       tag_match,
    output btb_entry_pkg::btb_target_t target,
    output btb_entry_pkg::btb_fip_t    fip_e,
    output btb_entry_pkg::btb_fip_t    fip_o
);

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    logic        valid_q;
    btb_tag_t    tag_q;
    btb_target_t target_q;
    btb_fip_t    fip_e_q;
    btb_fip_t    fip_o_q;

    // storage
    // a write lands on the edge, so a lookup in the same cycle
    // still reads the previous contents
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            tag_q    <= '0;
            target_q <= '0;
            fip_e_q  <= '0;
            fip_o_q  <= '0;
        end else if (write_en) begin
            valid_q  <= 1'b1;         // stays set until reset
            tag_q    <= wr_tag;
            target_q <= wr_target;
            fip_e_q  <= wr_fip_e;
            fip_o_q  <= wr_fip_o;
        end
    end

    // tag compare, only a filled entry can match
    assign tag_match = valid_q && (tag_q == lookup_tag);

    assign target = target_q;
    assign fip_e  = fip_e_q;
    assign fip_o  = fip_o_q;

endmodule

`default_nettype wire

// File: btb/btb_lookup_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_settings.svh"

module btb_lookup_select (
    input  btb_addr_pkg::btb_eip_u               fetch_eip,
    input  logic [`BTB_ENTRIES-1:0]              tag_match,   // valid and tag equal, per entry
    input  logic [`BTB_ENTRIES*32-1:0]           target_bus,
    input  logic [`BTB_ENTRIES*`BTB_FIP_BITS-1:0] fip_e_bus,
    input  logic [`BTB_ENTRIES*`BTB_FIP_BITS-1:0] fip_o_bus,
    output logic                                 hit,
    output btb_entry_pkg::btb_target_t           eip_target,
    output btb_entry_pkg::btb_fip_t              fip_e_target,
    output btb_entry_pkg::btb_fip_t              fip_o_target
);

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    localparam int TGT_W = $bits(btb_target_t);
    localparam int FIP_W = $bits(btb_fip_t);

    btb_index_t              rd_index;
    logic [`BTB_ENTRIES-1:0] rd_sel;     // one-hot entry select
    btb_target_t             target_mux;
    btb_fip_t                fip_e_mux;
    btb_fip_t                fip_o_mux;

    assign rd_index = fetch_eip.f.index;

    always_comb begin
        rd_sel = '0;
        rd_sel[rd_index] = 1'b1;
    end

    // only the indexed entry may hit, a match elsewhere is ignored
    assign hit = |(rd_sel & tag_match);

    // and-or mux over the entries
    always_comb begin
        target_mux = '0;
        fip_e_mux  = '0;
        fip_o_mux  = '0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            if (rd_sel[i]) begin
                target_mux |= target_bus[i*TGT_W +: TGT_W];
                fip_e_mux  |= fip_e_bus[i*FIP_W +: FIP_W];
                fip_o_mux  |= fip_o_bus[i*FIP_W +: FIP_W];
            end
        end
    end

    // a miss returns zero payload
    assign eip_target   = hit ? target_mux : '0;
    assign fip_e_target = hit ? fip_e_mux  : '0;
    assign fip_o_target = hit ? fip_o_mux  : '0;

endmodule

`default_nettype wire

// File: btb/btb_update_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_settings.svh"

module btb_update_decode (
    input  logic                       update_valid,  // writeback strobe
    input  btb_addr_pkg::btb_eip_u     update_eip,
    input  btb_entry_pkg::btb_target_t update_target,
    input  logic [31:0]                update_fip_e,
    input  logic [31:0]                update_fip_o,
    output logic [`BTB_ENTRIES-1:0]    write_en,
    output btb_addr_pkg::btb_tag_t     wr_tag,
    output btb_entry_pkg::btb_target_t wr_target,
    output btb_entry_pkg::btb_fip_t    wr_fip_e,
    output btb_entry_pkg::btb_fip_t    wr_fip_o
);

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    btb_index_t wr_index;

    assign wr_index = update_eip.f.index;

    // one-hot write enable, all zero without the strobe
    always_comb begin
        write_en = '0;
        if (update_valid) begin
            write_en[wr_index] = 1'b1;
        end
    end

    // write data is shared by every entry
    assign wr_tag    = update_eip.f.tag;
    assign wr_target = update_target;

    // only the line part of each fetch ip is kept
    assign wr_fip_e = update_fip_e[31:BTB_FIP_LSB];
    assign wr_fip_o = update_fip_o[31:BTB_FIP_LSB];

endmodule

`default_nettype wire

// File: common/btb_addr_pkg.sv
`default_nettype none

`include "btb_settings.svh"

package btb_addr_pkg;

    typedef logic [`BTB_TAG_BITS-1:0]   btb_tag_t;    // upper eip bits
    typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t;  // selects the entry

    // field view of an eip, tag on top
    typedef struct packed {
        btb_tag_t   tag;
        btb_index_t index;
    } btb_eip_fields_t;

    // same 32 bit word, either as it arrives or split for the buffer
    typedef union packed {
        logic [31:0]     raw;
        btb_eip_fields_t f;
    } btb_eip_u;

endpackage

`default_nettype wire

// File: common/btb_entry_pkg.sv
`default_nettype none

`include "btb_settings.svh"

package btb_entry_pkg;

    // full eip of the predicted branch target
    typedef logic [31:0] btb_target_t;

    // 16 byte fetch line address, fip[31:4]
    typedef logic [`BTB_FIP_BITS-1:0] btb_fip_t;

    // lowest fetch ip bit that survives in a line address
    localparam int BTB_FIP_LSB = 32 - `BTB_FIP_BITS;

endpackage

`default_nettype wire

// File: common/btb_settings.svh
`ifndef BTB_SETTINGS_SVH
`define BTB_SETTINGS_SVH

// geometry of the branch target buffer

`define BTB_ENTRIES     64  // direct mapped, one entry per index
`define BTB_INDEX_BITS  6   // eip[5:0]
`define BTB_TAG_BITS    26  // eip[31:6]

// a fetch line is 16 bytes, so the line address drops eip[3:0]
`define BTB_FIP_BITS    28

`endif

// File: hdl/btb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_settings.svh"

module btb_top (
    input  logic                       clk,
    input  logic                       rst_n,

    // lookup side, from fetch
    input  logic [31:0]                fetch_eip,
    output logic                       hit,
    output btb_entry_pkg::btb_target_t eip_target,
    output btb_entry_pkg::btb_fip_t    fip_e_target,   // even line of the target
    output btb_entry_pkg::btb_fip_t    fip_o_target,   // odd line of the target

    // update side, from writeback
    input  logic                       update_valid,
    input  logic [31:0]                update_eip,
    input  btb_entry_pkg::btb_target_t update_target,
    input  logic [31:0]                update_fip_e,
    input  logic [31:0]                update_fip_o
);

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    localparam int TGT_W = $bits(btb_target_t);
    localparam int FIP_W = $bits(btb_fip_t);

    btb_eip_u fetch_u;
    btb_eip_u update_u;

    logic [`BTB_ENTRIES-1:0] write_en;
    btb_tag_t                wr_tag;
    btb_target_t             wr_target;
    btb_fip_t                wr_fip_e;
    btb_fip_t                wr_fip_o;

    logic [`BTB_ENTRIES-1:0]       tag_match;
    logic [`BTB_ENTRIES*TGT_W-1:0] target_bus;   // entry i at [i*TGT_W +: TGT_W]
    logic [`BTB_ENTRIES*FIP_W-1:0] fip_e_bus;
    logic [`BTB_ENTRIES*FIP_W-1:0] fip_o_bus;

    assign fetch_u.raw  = fetch_eip;
    assign update_u.raw = update_eip;

    btb_update_decode u_update_decode (
        .update_valid  (update_valid),
        .update_eip    (update_u),
        .update_target (update_target),
        .update_fip_e  (update_fip_e),
        .update_fip_o  (update_fip_o),
        .write_en      (write_en),
        .wr_tag        (wr_tag),
        .wr_target     (wr_target),
        .wr_fip_e      (wr_fip_e),
        .wr_fip_o      (wr_fip_o)
    );

    // one entry per index, all see the same write data and lookup tag
    for (genvar i = 0; i < `BTB_ENTRIES; i++) begin : g_entry
        btb_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .write_en   (write_en[i]),
            .wr_tag     (wr_tag),
            .wr_target  (wr_target),
            .wr_fip_e   (wr_fip_e),
            .wr_fip_o   (wr_fip_o),
            .lookup_tag (fetch_u.f.tag),
            .tag_match  (tag_match[i]),
            .target     (target_bus[i*TGT_W +: TGT_W]),
            .fip_e      (fip_e_bus[i*FIP_W +: FIP_W]),
            .fip_o      (fip_o_bus[i*FIP_W +: FIP_W])
        );
    end

    btb_lookup_select u_lookup_select (
        .fetch_eip    (fetch_u),
        .tag_match    (tag_match),
        .target_bus   (target_bus),
        .fip_e_bus    (fip_e_bus),
        .fip_o_bus    (fip_o_bus),
        .hit          (hit),
        .eip_target   (eip_target),
        .fip_e_target (fip_e_target),
        .fip_o_target (fip_o_target)
    );

endmodule

`default_nettype wire

// File: project.f
+incdir+common
common/btb_addr_pkg.sv
common/btb_entry_pkg.sv
btb/btb_update_decode.sv
btb/btb_entry.sv
btb/btb_lookup_select.sv
hdl/btb_top.sv
test/btb_props.sv
test/btb_tb.sv

// File: test/btb_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_settings.svh"

module btb_props (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire logic                    update_valid,
    input wire logic [31:0]             update_eip,
    input wire logic [31:0]             fetch_eip,
    input wire logic                    hit,
    input wire logic [`BTB_ENTRIES-1:0] write_en
);

    int failures = 0;

    // decoder never enables more than one entry
    a_write_onehot : assert property (@(posedge clk) $onehot0(write_en))
        else begin
            $error("write_en has more than one bit set");
            failures++;
        end

    a_write_idle : assert property (@(posedge clk) !update_valid |-> write_en == '0)
        else begin
            $error("write_en active without update_valid");
            failures++;
        end

    // nothing can hit while every valid bit is still clear
    a_no_hit_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> !hit)
        else begin
            $error("hit seen right after reset release");
            failures++;
        end

    // a write is visible to a lookup of the same eip one cycle later
    a_update_visible : assert property (@(posedge clk)
        (update_valid && rst_n) |=> ((fetch_eip != $past(update_eip)) || hit))
        else begin
            $error("lookup missed an eip written in the previous cycle");
            failures++;
        end

endmodule

bind btb_top btb_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .update_valid (update_valid),
    .update_eip   (update_eip),
    .fetch_eip    (fetch_eip),
    .hit          (hit),
    .write_en     (write_en)
);

`default_nettype wire

// File: test/btb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "btb_settings.svh"

module btb_tb;

    import btb_addr_pkg::*;
    import btb_entry_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int N_IDLE       = 16;   // lookups right after reset
    localparam int N_PAIRS      = 4;
    localparam int N_UPDATES    = 100;
    localparam int N_LOOKUPS    = 200;
    localparam int N_SAME_CYCLE = 4;
    localparam int N_PROBES     = 8;
    // cycles spent by all tests with reset counted twice
    localparam int TEST_CYCLES  = 2 * (RESET_CYCLES + 1) + N_IDLE + 3 * N_PAIRS + 12
                                + 2 * N_UPDATES + N_LOOKUPS + 2 * N_SAME_CYCLE
                                + 2 * N_PROBES;
    localparam int MAX_CYCLES   = TEST_CYCLES + 50;

    logic        clk;
    logic        rst_n;
    logic [31:0] fetch_eip;
    logic        update_valid;
    logic [31:0] update_eip;
    btb_target_t update_target;
    logic [31:0] update_fip_e;
    logic [31:0] update_fip_o;
    logic        hit;
    btb_target_t eip_target;
    btb_fip_t    fip_e_target;
    btb_fip_t    fip_o_target;

    // reference model indexed by eip[5:0]
    logic        ref_valid  [`BTB_ENTRIES];
    btb_tag_t    ref_tag    [`BTB_ENTRIES];
    btb_target_t ref_target [`BTB_ENTRIES];
    btb_fip_t    ref_fip_e  [`BTB_ENTRIES];
    btb_fip_t    ref_fip_o  [`BTB_ENTRIES];

    logic [31:0] written[$];           // eips written so far
    logic [15:0] lfsr_state = 16'd46646;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    btb_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_eip     (fetch_eip),
        .hit           (hit),
        .eip_target    (eip_target),
        .fip_e_target  (fip_e_target),
        .fip_o_target  (fip_o_target),
        .update_valid  (update_valid),
        .update_eip    (update_eip),
        .update_target (update_target),
        .update_fip_e  (update_fip_e),
        .update_fip_o  (update_fip_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles, a test did not finish", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    task automatic model_write(input logic [31:0] eip, input btb_target_t tgt,
                               input logic [31:0] fe, input logic [31:0] fo);
        int idx;
        idx             = eip[5:0];
        ref_valid[idx]  = 1'b1;
        ref_tag[idx]    = eip[31:6];
        ref_target[idx] = tgt;
        ref_fip_e[idx]  = fe[31:4];   // 16 byte line address
        ref_fip_o[idx]  = fo[31:4];
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL @%0t: %s hit got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_target(input btb_target_t got, input btb_target_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL @%0t: %s target got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_fip(input btb_fip_t got, input btb_fip_t exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("FAIL @%0t: %s fip got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // compares the current outputs against the model for this eip
    task automatic expect_lookup(input logic [31:0] eip, input string what);
        int          idx;
        logic        exp_hit;
        btb_target_t exp_target;
        btb_fip_t    exp_fe;
        btb_fip_t    exp_fo;
        idx        = eip[5:0];
        exp_hit    = ref_valid[idx] && (ref_tag[idx] == eip[31:6]);
        exp_target = exp_hit ? ref_target[idx] : '0;
        exp_fe     = exp_hit ? ref_fip_e[idx] : '0;
        exp_fo     = exp_hit ? ref_fip_o[idx] : '0;
        check_hit(hit, exp_hit, what);
        check_target(eip_target, exp_target, what);
        check_fip(fip_e_target, exp_fe, {what, " even"});
        check_fip(fip_o_target, exp_fo, {what, " odd"});
    endtask

    task automatic lookup(input logic [31:0] eip, input string what);
        @(posedge clk);
        fetch_eip <= eip;
        @(negedge clk);
        expect_lookup(eip, what);
    endtask

    task automatic write_entry(input logic [31:0] eip, input btb_target_t tgt,
                               input logic [31:0] fe, input logic [31:0] fo);
        @(posedge clk);
        update_valid  <= 1'b1;
        update_eip    <= eip;
        update_target <= tgt;
        update_fip_e  <= fe;
        update_fip_o  <= fo;
        @(posedge clk);
        update_valid <= 1'b0;
        model_write(eip, tgt, fe, fo);   // the dut took it on this edge
        written.push_back(eip);
    endtask

    task automatic write_random(input logic [31:0] eip);
        write_entry(eip, lfsr_bits(32), lfsr_bits(32), lfsr_bits(32));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n        <= 1'b0;
        update_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        model_clear();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("%-20s %s, %0d errors", name,
                 (errors == errors_before) ? "ok" : "failed", errors - errors_before);
    endtask

    task automatic idle_lookups_miss();
        int e0;
        e0 = errors;
        repeat (N_IDLE) lookup(lfsr_bits(32), "idle");
        finish_test("idle_lookups_miss", e0);
    endtask

    task automatic write_then_read();
        int          e0;
        logic [31:0] eip;
        e0 = errors;
        repeat (N_PAIRS) begin
            eip = lfsr_bits(32);
            write_random(eip);
            lookup(eip, "write then read");
        end
        finish_test("write_then_read", e0);
    endtask

    task automatic alias_and_replace();
        int          e0;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        e0 = errors;
        a  = lfsr_bits(32);
        b  = {~a[31:6], a[5:0]};          // same index, other tag
        c  = {a[31:6], a[5:0] + 6'd1};    // same tag at the next index
        write_random(a);
        lookup(b, "alias before replace");
        lookup(c, "tag at other index");
        lookup(a, "first owner");
        write_random(b);
        lookup(a, "replaced owner");
        lookup(b, "new owner");
        check_hit(hit, 1'b1, "new owner direct");
        finish_test("alias_and_replace", e0);
    endtask

    task automatic random_traffic();
        int          e0;
        logic [31:0] eip;
        e0 = errors;
        repeat (N_UPDATES) write_random(lfsr_bits(32));
        repeat (N_LOOKUPS) begin
            // half from the written list, half fresh
            if (lfsr_bits(1))
                eip = written[lfsr_bits(16) % written.size()];
            else
                eip = lfsr_bits(32);
            lookup(eip, "random");
        end
        finish_test("random_traffic", e0);
    endtask

    task automatic same_cycle_update();
        int          e0;
        logic [31:0] eip;
        btb_target_t tgt;
        logic [31:0] fe;
        logic [31:0] fo;
        e0 = errors;
        for (int k = 0; k < N_SAME_CYCLE; k++) begin
            eip = written[written.size() - 1 - k];
            tgt = lfsr_bits(32);
            fe  = lfsr_bits(32);
            fo  = lfsr_bits(32);
            @(posedge clk);
            fetch_eip     <= eip;
            update_valid  <= 1'b1;
            update_eip    <= eip;
            update_target <= tgt;
            update_fip_e  <= fe;
            update_fip_o  <= fo;
            @(negedge clk);
            expect_lookup(eip, "same cycle old");   // model not yet written
            @(posedge clk);
            update_valid <= 1'b0;
            model_write(eip, tgt, fe, fo);
            @(negedge clk);
            expect_lookup(eip, "same cycle new");
        end
        finish_test("same_cycle_update", e0);
    endtask

    task automatic reset_clears_all();
        int          e0;
        logic [31:0] probes[N_PROBES];
        e0 = errors;
        for (int k = 0; k < N_PROBES; k++) begin
            probes[k] = written[written.size() - 1 - k];
            lookup(probes[k], "before reset");
        end
        apply_reset();
        for (int k = 0; k < N_PROBES; k++) begin
            lookup(probes[k], "after reset");
            check_hit(hit, 1'b0, "after reset direct");
        end
        finish_test("reset_clears_all", e0);
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        fetch_eip     = '0;
        update_valid  = 1'b0;
        update_eip    = '0;
        update_target = '0;
        update_fip_e  = '0;
        update_fip_o  = '0;
        model_clear();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        idle_lookups_miss();
        write_then_read();
        alias_and_replace();
        random_traffic();
        same_cycle_update();
        reset_clears_all();

        $display("%0d checks, %0d errors, %0d assertion failures, %0d cycles",
                 checks, errors, dut.u_props.failures, cycle_count);
        if (errors == 0 && dut.u_props.failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
